// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_exec_top
FILELIST   := exec_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu #(
  parameter int DATA_W = 8
) (
  input  logic [DATA_W-1:0]    a,
  input  logic [DATA_W-1:0]    b,
  input  cpu_isa_pkg::alu_op_e op,
  input  logic                 carry_in,
  output logic [DATA_W-1:0]    result,
  output logic                 carry_out,
  output logic                 carry_we,
  output logic                 zn_we
);

  logic [DATA_W:0] ext;  // Top bit is carry or borrow

  always_comb begin
    ext       = '0;
    result    = '0;
    carry_out = carry_in;
    carry_we  = 1'b0;
    zn_we     = 1'b0;

    case (op)
      cpu_isa_pkg::ALU_MOV: result = b;
      cpu_isa_pkg::ALU_ADD: begin
        ext = {1'b0, a} + {1'b0, b};
        {carry_out, result} = ext;
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_SUB: begin
        ext = {1'b0, a} - {1'b0, b};  // Also serves LOOP
        {carry_out, result} = ext;
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_AND: begin
        result = a & b;
        zn_we  = 1'b1;
      end
      cpu_isa_pkg::ALU_OR: begin
        result = a | b;
        zn_we  = 1'b1;
      end
      cpu_isa_pkg::ALU_RLC: begin
        {carry_out, result} = {b, carry_in};
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_RRC: begin
        {result, carry_out} = {carry_in, b};
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_SETC: begin
        carry_out = 1'b1;
        carry_we  = 1'b1;
      end
      cpu_isa_pkg::ALU_CLRC: begin
        carry_out = 1'b0;
        carry_we  = 1'b1;
      end
      cpu_isa_pkg::ALU_NOT: begin
        result = ~b;
        zn_we  = 1'b1;
      end
      cpu_isa_pkg::ALU_NEG: begin
        ext = {(DATA_W+1){1'b0}} - {1'b0, b};  // Borrow unless b is zero
        {carry_out, result} = ext;
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_INC: begin
        ext = {1'b0, b} + 1'b1;
        {carry_out, result} = ext;
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      cpu_isa_pkg::ALU_DEC: begin
        ext = {1'b0, b} - 1'b1;
        {carry_out, result} = ext;
        carry_we = 1'b1;
        zn_we    = 1'b1;
      end
      default: result = '0;
    endcase
  end

  always_comb begin
    if (!$isunknown({a, b, carry_in})) begin
      assert final (!$isunknown(op))
        else $error("alu: unknown op with known operands");
    end
  end

endmodule

// ==== design/bus_map_pkg.sv ====
package bus_map_pkg;

  localparam int WB_DW = 32;  // Bus data width
  localparam int WB_AW = 3;   // Word address width

  // Word addresses of the slave
  localparam logic [WB_AW-1:0] ADDR_INSTR = 3'd0;
  localparam logic [WB_AW-1:0] ADDR_REG0  = 3'd1;
  localparam logic [WB_AW-1:0] ADDR_REG1  = 3'd2;
  localparam logic [WB_AW-1:0] ADDR_REG2  = 3'd3;
  localparam logic [WB_AW-1:0] ADDR_REG3  = 3'd4;
  localparam logic [WB_AW-1:0] ADDR_FLAGS = 3'd5;  // C bit 0, Z bit 1, N bit 2
  localparam logic [WB_AW-1:0] ADDR_OUT   = 3'd6;

endpackage

// ==== design/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  cpu_isa_pkg::opcode_e  opcode,
  input  logic [1:0]            ra,
  output cpu_isa_pkg::alu_op_e  alu_op,
  output logic                  use_ra,
  output logic                  use_rb,
  output cpu_isa_pkg::res_sel_e res_sel,
  output cpu_isa_pkg::dst_sel_e dst_sel,
  output logic                  reg_we,
  output logic                  flag_we,
  output logic                  out_we
);

  always_comb begin
    alu_op  = cpu_isa_pkg::ALU_NOP;
    use_ra  = 1'b0;                  // Operand a is zero
    use_rb  = 1'b0;                  // Operand b is one
    res_sel = cpu_isa_pkg::RES_ALU;
    dst_sel = cpu_isa_pkg::DST_RA;
    reg_we  = 1'b0;
    flag_we = 1'b0;
    out_we  = 1'b0;

    case (opcode)
      cpu_isa_pkg::OPC_MOV: begin
        alu_op  = cpu_isa_pkg::ALU_MOV;
        use_rb  = 1'b1;
        res_sel = cpu_isa_pkg::RES_RB;   // Forward R[rb]
        reg_we  = 1'b1;
      end
      cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_SUB,
      cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_OR: begin
        // Opcode and ALU code line up for the two-operand group
        alu_op  = cpu_isa_pkg::alu_op_e'(opcode);
        use_ra  = 1'b1;
        use_rb  = 1'b1;
        reg_we  = 1'b1;
        flag_we = 1'b1;
      end
      cpu_isa_pkg::OPC_ROT_CARRY: begin
        flag_we = 1'b1;
        case (ra)
          2'd0: alu_op = cpu_isa_pkg::ALU_RLC;
          2'd1: alu_op = cpu_isa_pkg::ALU_RRC;
          2'd2: alu_op = cpu_isa_pkg::ALU_SETC;
          default: alu_op = cpu_isa_pkg::ALU_CLRC;
        endcase
        if (!ra[1]) begin                // Rotates write R[rb] back
          use_rb  = 1'b1;
          dst_sel = cpu_isa_pkg::DST_RB;
          reg_we  = 1'b1;
        end
      end
      cpu_isa_pkg::OPC_STACK_IO: begin
        if (ra == 2'd2) begin            // Only OUT acts here
          use_rb  = 1'b1;
          res_sel = cpu_isa_pkg::RES_RB;
          out_we  = 1'b1;
        end
      end
      cpu_isa_pkg::OPC_UNARY: begin
        // NOT, NEG, INC, DEC follow ra in order
        alu_op  = cpu_isa_pkg::alu_op_e'({2'b10, ra} + 4'd2);
        use_rb  = 1'b1;
        dst_sel = cpu_isa_pkg::DST_RB;
        reg_we  = 1'b1;
        flag_we = 1'b1;
      end
      cpu_isa_pkg::OPC_LOOP: begin
        alu_op  = cpu_isa_pkg::ALU_SUB;  // R[ra] - 1
        use_ra  = 1'b1;
        reg_we  = 1'b1;
        flag_we = 1'b1;
      end
      cpu_isa_pkg::OPC_LDM: begin
        res_sel = cpu_isa_pkg::RES_IMM;
        dst_sel = cpu_isa_pkg::DST_RB;
        reg_we  = 1'b1;
      end
      cpu_isa_pkg::OPC_CALL_RET, cpu_isa_pkg::OPC_LDD, cpu_isa_pkg::OPC_STD: begin
        alu_op = cpu_isa_pkg::ALU_NOP;   // Waits for a memory stage
      end
      default: begin
        alu_op = cpu_isa_pkg::ALU_NOP;
      end
    endcase
  end

endmodule

// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  // Instruction word layout on the bus
  localparam int OPC_LSB = 12;
  localparam int OPC_W   = 4;
  localparam int RA_LSB  = 10;
  localparam int RB_LSB  = 8;
  localparam int REG_AW  = 2;
  localparam int IMM_LSB = 0;

  typedef enum logic [OPC_W-1:0] {
    OPC_MOV       = 4'd1,
    OPC_ADD       = 4'd2,
    OPC_SUB       = 4'd3,
    OPC_AND       = 4'd4,
    OPC_OR        = 4'd5,
    OPC_ROT_CARRY = 4'd6,   // RLC, RRC, SETC, CLRC by ra
    OPC_STACK_IO  = 4'd7,   // PUSH, POP, OUT by ra
    OPC_UNARY     = 4'd8,   // NOT, NEG, INC, DEC by ra
    OPC_LOOP      = 4'd10,
    OPC_CALL_RET  = 4'd11,  // CALL, RET, RTI by ra
    OPC_LDM       = 4'd12,
    OPC_LDD       = 4'd13,
    OPC_STD       = 4'd14
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_MOV  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_RLC  = 4'd6,
    ALU_RRC  = 4'd7,
    ALU_SETC = 4'd8,
    ALU_CLRC = 4'd9,
    ALU_NOT  = 4'd10,
    ALU_NEG  = 4'd11,
    ALU_INC  = 4'd12,
    ALU_DEC  = 4'd13
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_IMM = 2'd1,
    RES_RB  = 2'd2
  } res_sel_e;

  typedef enum logic {
    DST_RA = 1'b0,
    DST_RB = 1'b1
  } dst_sel_e;

endpackage

// ==== design/exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
  parameter int DATA_W = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 instr_valid,
  input  cpu_isa_pkg::opcode_e opcode,
  input  logic [1:0]           ra,
  input  logic [1:0]           rb,
  input  logic [DATA_W-1:0]    imm,
  input  logic [1:0]           bus_reg_sel,
  output logic [DATA_W-1:0]    bus_reg_data,
  output logic [2:0]           flags,
  output logic [DATA_W-1:0]    out_port
);

  cpu_isa_pkg::alu_op_e  alu_op;
  cpu_isa_pkg::res_sel_e res_sel;
  cpu_isa_pkg::dst_sel_e dst_sel;
  logic                  use_ra;
  logic                  use_rb;
  logic                  reg_we;
  logic                  flag_we;
  logic                  out_we;
  logic [DATA_W-1:0]     rd_data_a;
  logic [DATA_W-1:0]     rd_data_b;
  logic [DATA_W-1:0]     op_a;
  logic [DATA_W-1:0]     op_b;
  logic [DATA_W-1:0]     alu_res;
  logic [DATA_W-1:0]     wb_data;
  logic [1:0]            wr_addr;
  logic                  carry_out;
  logic                  carry_we;
  logic                  zn_we;
  logic                  c_flag;
  logic                  z_flag;
  logic                  n_flag;

  control_unit u_cu (
    .opcode (opcode),
    .ra     (ra),
    .alu_op (alu_op),
    .use_ra (use_ra),
    .use_rb (use_rb),
    .res_sel(res_sel),
    .dst_sel(dst_sel),
    .reg_we (reg_we),
    .flag_we(flag_we),
    .out_we (out_we)
  );

  assign op_a = use_ra ? rd_data_a : '0;
  assign op_b = use_rb ? rd_data_b : DATA_W'(1);  // Constant one for LOOP

  alu #(.DATA_W(DATA_W)) u_alu (
    .a        (op_a),
    .b        (op_b),
    .op       (alu_op),
    .carry_in (c_flag),
    .result   (alu_res),
    .carry_out(carry_out),
    .carry_we (carry_we),
    .zn_we    (zn_we)
  );

  always_comb begin
    case (res_sel)
      cpu_isa_pkg::RES_IMM: wb_data = imm;
      cpu_isa_pkg::RES_RB:  wb_data = rd_data_b;
      default:              wb_data = alu_res;
    endcase
  end

  assign wr_addr = (dst_sel == cpu_isa_pkg::DST_RB) ? rb : ra;

  reg_file #(.DATA_W(DATA_W)) u_rf (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd_addr_a(ra),
    .rd_addr_b(rb),
    .rd_addr_c(bus_reg_sel),
    .we       (instr_valid && reg_we),
    .wr_addr  (wr_addr),
    .wr_data  (wb_data),
    .rd_data_a(rd_data_a),
    .rd_data_b(rd_data_b),
    .rd_data_c(bus_reg_data)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      c_flag   <= 1'b0;
      z_flag   <= 1'b0;
      n_flag   <= 1'b0;
      out_port <= '0;
    end else if (instr_valid) begin
      if (flag_we && carry_we) begin
        c_flag <= carry_out;
      end
      if (flag_we && zn_we) begin
        z_flag <= (alu_res == '0);
        n_flag <= alu_res[DATA_W-1];
      end
      if (out_we) begin
        out_port <= rd_data_b;
      end
    end
  end

  assign flags = {n_flag, z_flag, c_flag};

  // The slave issues one instruction per bus transfer
  a_single_issue: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid |=> !instr_valid)
    else $error("exec_core: instr_valid held for two cycles");

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/1ps

module exec_top #(
  parameter int DATA_W = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [bus_map_pkg::WB_AW-1:0] adr,
  input  logic [bus_map_pkg::WB_DW-1:0] dat_w,
  output logic [bus_map_pkg::WB_DW-1:0] dat_r,
  output logic                          ack,
  output logic [DATA_W-1:0]             out_port
);

  logic                 instr_valid;
  cpu_isa_pkg::opcode_e opcode;
  logic [1:0]           ra;
  logic [1:0]           rb;
  logic [DATA_W-1:0]    imm;
  logic [1:0]           bus_reg_sel;
  logic [DATA_W-1:0]    bus_reg_data;
  logic [2:0]           flags;

  wb_exec_slave #(.DATA_W(DATA_W)) u_slave (
    .clk         (clk),
    .arst_n      (arst_n),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .dat_w       (dat_w),
    .bus_reg_data(bus_reg_data),
    .flags       (flags),
    .out_port    (out_port),
    .ack         (ack),
    .dat_r       (dat_r),
    .instr_valid (instr_valid),
    .opcode      (opcode),
    .ra          (ra),
    .rb          (rb),
    .imm         (imm),
    .bus_reg_sel (bus_reg_sel)
  );

  exec_core #(.DATA_W(DATA_W)) u_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .opcode      (opcode),
    .ra          (ra),
    .rb          (rb),
    .imm         (imm),
    .bus_reg_sel (bus_reg_sel),
    .bus_reg_data(bus_reg_data),
    .flags       (flags),
    .out_port    (out_port)
  );

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [1:0]        rd_addr_a,
  input  logic [1:0]        rd_addr_b,
  input  logic [1:0]        rd_addr_c,
  input  logic              we,
  input  logic [1:0]        wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] rd_data_a,
  output logic [DATA_W-1:0] rd_data_b,
  output logic [DATA_W-1:0] rd_data_c
);

  logic [DATA_W-1:0] regs [4];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads see the old value during a write
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];
  assign rd_data_c = regs[rd_addr_c];  // Bus read port

endmodule

// ==== design/wb_exec_slave.sv ====
`timescale 1ns/1ps

module wb_exec_slave #(
  parameter int DATA_W = 8
) (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                cyc,
  input  logic                                stb,
  input  logic                                we,
  input  logic [bus_map_pkg::WB_AW-1:0]       adr,
  input  logic [bus_map_pkg::WB_DW-1:0]       dat_w,
  input  logic [DATA_W-1:0]                   bus_reg_data,
  input  logic [2:0]                          flags,
  input  logic [DATA_W-1:0]                   out_port,
  output logic                                ack,
  output logic [bus_map_pkg::WB_DW-1:0]       dat_r,
  output logic                                instr_valid,
  output cpu_isa_pkg::opcode_e                opcode,
  output logic [cpu_isa_pkg::REG_AW-1:0]      ra,
  output logic [cpu_isa_pkg::REG_AW-1:0]      rb,
  output logic [DATA_W-1:0]                   imm,
  output logic [1:0]                          bus_reg_sel
);

  logic                          req;
  logic                          wr_pend;  // Write ack due next edge
  logic [bus_map_pkg::WB_DW-1:0] rd_word;

  // No new request while an ack is on its way
  assign req = cyc && stb && !ack && !wr_pend;

  assign bus_reg_sel = 2'(adr - bus_map_pkg::ADDR_REG0);

  always_comb begin
    rd_word = '0;
    case (adr)
      bus_map_pkg::ADDR_REG0, bus_map_pkg::ADDR_REG1,
      bus_map_pkg::ADDR_REG2, bus_map_pkg::ADDR_REG3: rd_word[DATA_W-1:0] = bus_reg_data;
      bus_map_pkg::ADDR_FLAGS: rd_word[2:0]        = flags;
      bus_map_pkg::ADDR_OUT:   rd_word[DATA_W-1:0] = out_port;
      default:                 rd_word             = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack         <= 1'b0;
      wr_pend     <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      ack         <= wr_pend || (req && !we);  // Reads answer one cycle earlier
      wr_pend     <= req && we;
      instr_valid <= req && we && (adr == bus_map_pkg::ADDR_INSTR);
    end
  end

  always_ff @(posedge clk) begin
    if (req && we && adr == bus_map_pkg::ADDR_INSTR) begin
      opcode <= cpu_isa_pkg::opcode_e'(dat_w[cpu_isa_pkg::OPC_LSB +: cpu_isa_pkg::OPC_W]);
      ra     <= dat_w[cpu_isa_pkg::RA_LSB +: cpu_isa_pkg::REG_AW];
      rb     <= dat_w[cpu_isa_pkg::RB_LSB +: cpu_isa_pkg::REG_AW];
      imm    <= dat_w[cpu_isa_pkg::IMM_LSB +: DATA_W];
    end
    if (req && !we) begin
      dat_r <= rd_word;
    end
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    ack |-> cyc && stb)
    else $error("wb_exec_slave: ack outside an active cycle");

endmodule

// ==== dv/tb_exec_top.sv ====
`timescale 1ns/1ps

module tb_exec_top;

  localparam int DW              = 8;
  localparam int N_INSTR         = 400;
  localparam int ACK_LIMIT       = 12;                        // Cycles a transfer may take
  localparam int WATCHDOG_CYCLES = N_INSTR * 8 * 12 + 2000;   // Random part plus directed part

  logic                                clk;
  logic                                arst_n;
  logic                                cyc;
  logic                                stb;
  logic                                we;
  logic [bus_map_pkg::WB_AW-1:0]       adr;
  logic [bus_map_pkg::WB_DW-1:0]       dat_w;
  logic [bus_map_pkg::WB_DW-1:0]       dat_r;
  logic                                ack;
  logic [DW-1:0]                       out_port;

  // Reference model state
  logic [DW-1:0] m_regs [4];
  logic          m_c;
  logic          m_z;
  logic          m_n;
  logic [DW-1:0] m_out;

  logic [31:0] rng_state;

  exec_top #(.DATA_W(DW)) i_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .out_port(out_port)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic fail_stop();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // Counts edges until ack shows up after one
  task automatic wait_ack(output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      lat++;
      if (lat > ACK_LIMIT) begin
        $display("no ack from the DUT within %0d cycles at %0t ns", ACK_LIMIT, $time);
        fail_stop();
      end
    end while (!ack);
  endtask

  // Master sees ack at the next edge, then drops stb for one idle cycle
  task automatic finish_transfer();
    @(posedge clk);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    check_value("ack pulse width", 32'(ack), 32'd0);
    @(posedge clk);
    #1;
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [31:0] data);
    int lat;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_ack(lat);
    check_value("write ack latency", 32'(lat), 32'd2);
    finish_transfer();
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [31:0] data);
    int lat;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    wait_ack(lat);
    check_value("read ack latency", 32'(lat), 32'd1);
    data = dat_r;
    finish_transfer();
  endtask

  task automatic model_exec(input logic [3:0] opc, input logic [1:0] ra,
                            input logic [1:0] rb, input logic [DW-1:0] imm);
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] res;
    logic          set_zn;
    a      = m_regs[ra];
    b      = m_regs[rb];
    res    = '0;
    set_zn = 1'b0;
    case (opc)
      cpu_isa_pkg::OPC_MOV: m_regs[ra] = b;
      cpu_isa_pkg::OPC_ADD: begin
        res = a + b;
        m_c = (res < a);  // Sum wrapped past the top
        m_regs[ra] = res;
        set_zn = 1'b1;
      end
      cpu_isa_pkg::OPC_SUB: begin
        res = a - b;
        m_c = (a < b);  // Borrow
        m_regs[ra] = res;
        set_zn = 1'b1;
      end
      cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_OR: begin
        res = (opc == cpu_isa_pkg::OPC_AND) ? (a & b) : (a | b);
        m_regs[ra] = res;
        set_zn = 1'b1;
      end
      cpu_isa_pkg::OPC_ROT_CARRY: begin
        case (ra)
          2'd0: begin
            res = {b[DW-2:0], m_c};
            m_c = b[DW-1];
          end
          2'd1: begin
            res = {m_c, b[DW-1:1]};
            m_c = b[0];
          end
          2'd2: m_c = 1'b1;
          default: m_c = 1'b0;
        endcase
        if (!ra[1]) begin
          m_regs[rb] = res;
          set_zn = 1'b1;
        end
      end
      cpu_isa_pkg::OPC_STACK_IO: begin
        if (ra == 2'd2) m_out = b;  // Only OUT acts in this slice
      end
      cpu_isa_pkg::OPC_UNARY: begin
        case (ra)
          2'd0: res = ~b;
          2'd1: begin
            res = '0 - b;
            m_c = (b != '0);
          end
          2'd2: begin
            res = b + DW'(1);
            m_c = (b == '1);
          end
          default: begin
            res = b - DW'(1);
            m_c = (b == '0);
          end
        endcase
        m_regs[rb] = res;
        set_zn = 1'b1;
      end
      cpu_isa_pkg::OPC_LOOP: begin
        res = a - DW'(1);
        m_c = (a == '0);
        m_regs[ra] = res;
        set_zn = 1'b1;
      end
      cpu_isa_pkg::OPC_LDM: m_regs[rb] = imm;
      default: ;  // Stack, call, memory and unused codes
    endcase
    if (set_zn) begin
      m_z = (res == '0);
      m_n = res[DW-1];
    end
  endtask

  task automatic issue_instr(input logic [3:0] opc, input logic [1:0] ra, input logic [1:0] rb,
                             input logic [7:0] imm, input logic [15:0] upper);
    bus_write(bus_map_pkg::ADDR_INSTR, {upper, opc, ra, rb, imm});
    model_exec(opc, ra, rb, DW'(imm));
  endtask

  task automatic check_state();
    logic [31:0] rd;
    for (int i = 0; i < 4; i++) begin
      bus_read(3'(int'(bus_map_pkg::ADDR_REG0) + i), rd);
      check_value($sformatf("dat_r R%0d", i), rd, 32'(m_regs[i]));
    end
    bus_read(bus_map_pkg::ADDR_FLAGS, rd);
    check_value("dat_r flags", rd, {29'd0, m_n, m_z, m_c});
    bus_read(bus_map_pkg::ADDR_OUT, rd);
    check_value("dat_r out_port", rd, 32'(m_out));
    check_value("out_port", 32'(out_port), 32'(m_out));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    fail_stop();
  end

  initial begin
    logic [31:0] r;
    arst_n    = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    rng_state = 32'h2bbcf66c;
    m_c       = 1'b0;
    m_z       = 1'b0;
    m_n       = 1'b0;
    m_out     = '0;
    for (int i = 0; i < 4; i++) begin
      m_regs[i] = '0;
    end

    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value("ack after reset", 32'(ack), 32'd0);
    @(posedge clk);
    #1;
    check_state();  // Everything reads zero

    // Immediate loads with junk in the upper word
    for (int i = 0; i < 4; i++) begin
      issue_instr(cpu_isa_pkg::OPC_LDM, 2'd3, 2'(i), 8'h3c ^ 8'(i * 8'h55), 16'hffff);
    end
    check_state();
    issue_instr(cpu_isa_pkg::OPC_MOV, 2'd0, 2'd2, 8'h00, 16'h0000);
    check_state();

    // Rotates through carry, then carry set and clear
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd2, 2'd0, 8'h00, 16'h0000);
    check_state();
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd0, 2'd1, 8'h00, 16'h0000);
    check_state();
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd1, 2'd3, 8'h00, 16'h0000);
    check_state();
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd3, 2'd3, 8'h00, 16'h0000);
    check_state();
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd1, 2'd2, 8'h00, 16'h0000);
    check_state();

    // OUT, then instructions that must leave all state alone
    issue_instr(cpu_isa_pkg::OPC_STACK_IO, 2'd2, 2'd1, 8'h00, 16'h0000);
    check_state();
    issue_instr(cpu_isa_pkg::OPC_ROT_CARRY, 2'd2, 2'd0, 8'h00, 16'h0000);
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      issue_instr(cpu_isa_pkg::OPC_STACK_IO, (k == 2) ? 2'd3 : 2'(k), r[25:24], r[23:16],
                  r[15:0]);
      issue_instr(cpu_isa_pkg::OPC_CALL_RET, 2'(k), r[27:26], r[23:16], r[15:0]);
    end
    r = next_rand();
    issue_instr(cpu_isa_pkg::OPC_LDD, r[27:26], r[25:24], r[23:16], r[15:0]);
    issue_instr(cpu_isa_pkg::OPC_STD, r[25:24], r[27:26], r[23:16], r[15:0]);
    bus_write(bus_map_pkg::ADDR_FLAGS, next_rand());  // Writes off the instruction word
    bus_write(bus_map_pkg::ADDR_REG2, next_rand());
    check_state();

    for (int i = 0; i < N_INSTR; i++) begin
      r = next_rand();
      issue_instr(r[31:28], r[27:26], r[25:24], r[23:16], r[15:0]);
      if (i % 16 == 15) begin
        bus_write(3'(i % 7 + 1), next_rand());
      end
      check_state();
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== exec_top.f ====
design/cpu_isa_pkg.sv
design/bus_map_pkg.sv
design/control_unit.sv
design/alu.sv
design/reg_file.sv
design/exec_core.sv
design/wb_exec_slave.sv
design/exec_top.sv
dv/tb_exec_top.sv
